// ==== common/rs_ctrl_pkg.sv ====
// Entry control types for the reservation station
// State encoding and the age used by the issue arbiter

`default_nettype none

`include "rs_params.svh"

package rs_ctrl_pkg;

   typedef enum logic [2:0] {
      EMPTY     = 3'b000,
      WAIT_A    = 3'b001,
      WAIT_B    = 3'b010,
      WAIT_BOTH = 3'b011,
      READY     = 3'b100
   } entry_state_t;

   // count of younger instructions, saturating, larger is older
   typedef logic [`RS_AGE_BITS-1:0] age_t;

   typedef struct packed {
      entry_state_t state;
      age_t         age;
   } entry_status_t;

endpackage

`default_nettype wire

// ==== common/rs_params.svh ====
// Reservation station sizing
// Entry count, bus widths and the tag value that marks "no producer"

`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// number of station entries
`define RS_NUM_ENTRIES 16

// producer tag width
`define RS_TAG_BITS 8

// operand and CDB value width
`define RS_VALUE_BITS 64

// width of the per-entry age counter
`define RS_AGE_BITS 8

// all ones means the operand is already valid or the CDB is idle
`define RS_TAG_NULL 8'hFF

`endif

// ==== common/rs_types_pkg.sv ====
// Instruction and bus types for the reservation station
// Covers the dispatch slots, the common data buses and the issue ports

`default_nettype none

`include "rs_params.svh"

package rs_types_pkg;

   typedef logic [`RS_VALUE_BITS-1:0] value_t;
   typedef logic [`RS_TAG_BITS-1:0]   tag_t;
   typedef logic [4:0]                dest_reg_t;
   typedef logic [4:0]                alu_func_t;

   // one decoded instruction offered by the dispatcher
   // a null tag means the value beside it is already valid
   typedef struct packed {
      logic      valid;
      alu_func_t alu_func;
      dest_reg_t dest_reg;
      tag_t      dest_tag;
      tag_t      tag_a;
      tag_t      tag_b;
      value_t    value_a;
      value_t    value_b;
   } dispatch_inst_t;

   // result broadcast, idle when the tag is null
   typedef struct packed {
      tag_t   tag;
      value_t value;
   } cdb_t;

   // instruction leaving toward the execute stage
   typedef struct packed {
      logic      valid;
      alu_func_t alu_func;
      dest_reg_t dest_reg;
      tag_t      dest_tag;
      value_t    op_a;
      value_t    op_b;
   } issue_inst_t;

endpackage

`default_nettype wire

// ==== reservation_station.f ====
+incdir+common
common/rs_types_pkg.sv
common/rs_ctrl_pkg.sv
rs_entry/rs_operand_wakeup.sv
rs_entry/rs_entry.sv
verilog/rs_dispatch_alloc.sv
verilog/rs_issue_select.sv
verilog/reservation_station.sv
tb/reservation_station_tb.sv

// ==== rs_entry/rs_entry.sv ====
// Reservation station entry
// Holds one instruction with its two operand slots, its state and its age

`timescale 1ns/1ns
`default_nettype none

`include "rs_params.svh"

module rs_entry
   import rs_types_pkg::*;
   import rs_ctrl_pkg::*;
(
   input  logic           clock,
   input  logic           reset,
   input  logic           fill,
   input  dispatch_inst_t fill_inst,
   input  age_t           fill_age,
   input  logic [1:0]     fill_count,
   input  cdb_t           cdb1,
   input  cdb_t           cdb2,
   input  logic           issued,
   output entry_status_t  status,
   output issue_inst_t    payload
);

   logic                  occupied;
   age_t                  age_q;
   logic [`RS_AGE_BITS:0] age_sum;
   age_t                  age_next;
   alu_func_t             alu_func_q;
   dest_reg_t             dest_reg_q;
   tag_t                  dest_tag_q;
   logic                  waiting_a;
   logic                  waiting_b;
   value_t                value_a;
   value_t                value_b;
   entry_state_t          state;

   ////////////////////////////////////////
   // operand slots
   ////////////////////////////////////////

   rs_operand_wakeup u_operand_a (
      .clock      (clock),
      .reset      (reset),
      .fill       (fill),
      .fill_tag   (fill_inst.tag_a),
      .fill_value (fill_inst.value_a),
      .cdb1       (cdb1),
      .cdb2       (cdb2),
      .waiting    (waiting_a),
      .value      (value_a)
   );

   rs_operand_wakeup u_operand_b (
      .clock      (clock),
      .reset      (reset),
      .fill       (fill),
      .fill_tag   (fill_inst.tag_b),
      .fill_value (fill_inst.value_b),
      .cdb1       (cdb1),
      .cdb2       (cdb2),
      .waiting    (waiting_b),
      .value      (value_b)
   );

   ////////////////////////////////////////
   // occupancy and age
   ////////////////////////////////////////

   // every dispatch after this one makes it older, held at the top value
   assign age_sum  = {1'b0, age_q} + {{(`RS_AGE_BITS-1){1'b0}}, fill_count};
   assign age_next = age_sum[`RS_AGE_BITS] ? '1 : age_sum[`RS_AGE_BITS-1:0];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         occupied <= 1'b0;
         age_q    <= '0;
      end
      else if (issued)
      begin
         occupied <= 1'b0;
         age_q    <= '0;
      end
      else if (fill)
      begin
         occupied <= 1'b1;
         age_q    <= fill_age;
      end
      else if (occupied)
         age_q <= age_next;
   end

   always_ff @(posedge clock)
   begin
      if (fill)
      begin
         alu_func_q <= fill_inst.alu_func;
         dest_reg_q <= fill_inst.dest_reg;
         dest_tag_q <= fill_inst.dest_tag;
      end
   end

   // state follows the operand slots so a wakeup is visible the next cycle
   always_comb
   begin
      if (!occupied)
         state = EMPTY;
      else
      begin
         case ({waiting_a, waiting_b})
            2'b00:   state = READY;
            2'b10:   state = WAIT_A;
            2'b01:   state = WAIT_B;
            default: state = WAIT_BOTH;
         endcase
      end
   end

   assign status.state = state;
   assign status.age   = age_q;

   assign payload.valid    = (state == READY);
   assign payload.alu_func = alu_func_q;
   assign payload.dest_reg = dest_reg_q;
   assign payload.dest_tag = dest_tag_q;
   assign payload.op_a     = value_a;
   assign payload.op_b     = value_b;

endmodule

`default_nettype wire

// ==== rs_entry/rs_operand_wakeup.sv ====
// Operand slot of a station entry
// Holds one source tag and value, captures the matching CDB result

`timescale 1ns/1ns
`default_nettype none

`include "rs_params.svh"

module rs_operand_wakeup
   import rs_types_pkg::*;
(
   input  logic   clock,
   input  logic   reset,
   input  logic   fill,
   input  tag_t   fill_tag,
   input  value_t fill_value,
   input  cdb_t   cdb1,
   input  cdb_t   cdb2,
   output logic   waiting,
   output value_t value
);

   tag_t   tag_q;
   value_t value_q;
   tag_t   probe_tag;
   logic   hit1;
   logic   hit2;

   // at fill the incoming tag is snooped, so a same-cycle broadcast is not lost
   assign probe_tag = fill ? fill_tag : tag_q;
   assign hit1      = (probe_tag != `RS_TAG_NULL) && (probe_tag == cdb1.tag);
   assign hit2      = (probe_tag != `RS_TAG_NULL) && (probe_tag == cdb2.tag);

   always_ff @(posedge clock)
   begin
      if (reset)
         tag_q <= `RS_TAG_NULL;
      else if (hit1 || hit2)
         tag_q <= `RS_TAG_NULL;
      else if (fill)
         tag_q <= fill_tag;
   end

   // cdb1 wins when both buses carry the tag
   always_ff @(posedge clock)
   begin
      if (hit1)
         value_q <= cdb1.value;
      else if (hit2)
         value_q <= cdb2.value;
      else if (fill)
         value_q <= fill_value;
   end

   assign waiting = (tag_q != `RS_TAG_NULL);
   assign value   = value_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the reservation station testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module reservation_station_tb \
   -f reservation_station.f -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vreservation_station_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
   exit 0
fi
exit 1

// ==== tb/reservation_station_tb.sv ====
// Testbench for the reservation station
// Applies a table of dispatch and CDB inputs, one row per cycle, and checks
// dispatch_accept and both issue ports against hand-derived values

`timescale 1ns/1ns
`default_nettype none

`include "rs_params.svh"

module reservation_station_tb
   import rs_types_pkg::*;
();

   localparam int             RESET_CYCLES = 16;
   localparam dispatch_inst_t NO_INST      = '0;
   localparam issue_inst_t    NO_ISSUE     = '0;
   localparam cdb_t           CDB_IDLE     = {`RS_TAG_NULL, 64'h0};
   localparam value_t         WAKE_40      = 64'h4040_4040_4040_4040;

   typedef struct packed {
      dispatch_inst_t inst1;
      dispatch_inst_t inst2;
      cdb_t           cdb1;
      cdb_t           cdb2;
      logic           accept;
      issue_inst_t    issue1;
      issue_inst_t    issue2;
   } row_t;

   logic           clock;
   logic           reset;
   dispatch_inst_t inst1;
   dispatch_inst_t inst2;
   cdb_t           cdb1;
   cdb_t           cdb2;
   logic           dispatch_accept;
   issue_inst_t    issue1;
   issue_inst_t    issue2;

   row_t rows[$];
   int   row_index;
   int   cycles;

   reservation_station DUT (
      .clock           (clock),
      .reset           (reset),
      .inst1           (inst1),
      .inst2           (inst2),
      .cdb1            (cdb1),
      .cdb2            (cdb2),
      .dispatch_accept (dispatch_accept),
      .issue1          (issue1),
      .issue2          (issue2)
   );

   ////////////////////////////////////////
   // row builders
   ////////////////////////////////////////

   // fill values carry the instruction number so a wrong pick stands out
   function automatic value_t operand_a(input logic [7:0] k);
      return {56'hAAAA_0000_0000_00, k};
   endfunction

   function automatic value_t operand_b(input logic [7:0] k);
      return {56'hBBBB_0000_0000_00, k};
   endfunction

   function automatic cdb_t make_cdb(input tag_t tag, input value_t value);
      cdb_t c;
      c.tag   = tag;
      c.value = value;
      return c;
   endfunction

   function automatic dispatch_inst_t make_inst(input logic [7:0] k, input tag_t ta,
                                                input tag_t tb);
      dispatch_inst_t d;
      d.valid    = 1'b1;
      d.alu_func = k[4:0];
      d.dest_reg = k[4:0];
      d.dest_tag = k;
      d.tag_a    = ta;
      d.tag_b    = tb;
      d.value_a  = operand_a(k);
      d.value_b  = operand_b(k);
      return d;
   endfunction

   function automatic issue_inst_t make_issue(input logic [7:0] k, input value_t a,
                                              input value_t b);
      issue_inst_t e;
      e.valid    = 1'b1;
      e.alu_func = k[4:0];
      e.dest_reg = k[4:0];
      e.dest_tag = k;
      e.op_a     = a;
      e.op_b     = b;
      return e;
   endfunction

   task automatic add_row(input dispatch_inst_t i1, input dispatch_inst_t i2,
                          input cdb_t c1, input cdb_t c2, input logic acc,
                          input issue_inst_t e1, input issue_inst_t e2);
      row_t r;
      r.inst1  = i1;
      r.inst2  = i2;
      r.cdb1   = c1;
      r.cdb2   = c2;
      r.accept = acc;
      r.issue1 = e1;
      r.issue2 = e2;
      rows.push_back(r);
   endtask

   // expected outputs of a row are those seen while its inputs are driven
   task automatic build_table();
      logic [7:0] o;
      tag_t       nt;
      nt = `RS_TAG_NULL;
      // reset state and then a ready pair with slot 1 older
      add_row(NO_INST, NO_INST, CDB_IDLE, CDB_IDLE, 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(make_inst(8'h01, nt, nt), make_inst(8'h02, nt, nt), CDB_IDLE, CDB_IDLE,
              1'b1, NO_ISSUE, NO_ISSUE);
      add_row(NO_INST, NO_INST, CDB_IDLE, CDB_IDLE, 1'b1,
              make_issue(8'h01, operand_a(8'h01), operand_b(8'h01)),
              make_issue(8'h02, operand_a(8'h02), operand_b(8'h02)));
      // the second instruction catches cdb2 in its own dispatch cycle
      add_row(make_inst(8'h03, 8'h20, nt), make_inst(8'h04, nt, 8'h21), CDB_IDLE,
              make_cdb(8'h21, 64'h7777), 1'b1, NO_ISSUE, NO_ISSUE);
      // entry 1 is still busy here so the older waiting pair lands in entries 2 and 3
      add_row(make_inst(8'h05, 8'h30, nt), make_inst(8'h06, 8'h30, nt), CDB_IDLE, CDB_IDLE,
              1'b1, make_issue(8'h04, operand_a(8'h04), 64'h7777), NO_ISSUE);
      // younger pair refills entries 1 and 4 while cdb2 wakes instruction 3
      add_row(make_inst(8'h07, 8'h30, nt), make_inst(8'h08, 8'h30, nt), CDB_IDLE,
              make_cdb(8'h20, 64'h8888), 1'b1, NO_ISSUE, NO_ISSUE);
      // one broadcast wakes all four and age must beat entry order
      add_row(NO_INST, NO_INST, make_cdb(8'h30, 64'h3030), CDB_IDLE, 1'b1,
              make_issue(8'h03, 64'h8888, operand_b(8'h03)), NO_ISSUE);
      add_row(NO_INST, NO_INST, CDB_IDLE, CDB_IDLE, 1'b1,
              make_issue(8'h05, 64'h3030, operand_b(8'h05)),
              make_issue(8'h06, 64'h3030, operand_b(8'h06)));
      add_row(NO_INST, NO_INST, CDB_IDLE, CDB_IDLE, 1'b1,
              make_issue(8'h07, 64'h3030, operand_b(8'h07)),
              make_issue(8'h08, 64'h3030, operand_b(8'h08)));
      // full station with 15 entries waiting on tag 40
      for (o = 8'h00; o < 8'h0E; o = o + 8'h02)
         add_row(make_inst(8'h80 | o, nt, 8'h40), make_inst(8'h80 | (o + 8'h01), nt, 8'h40),
                 CDB_IDLE, CDB_IDLE, 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(make_inst(8'h8E, nt, 8'h40), NO_INST, CDB_IDLE, CDB_IDLE, 1'b1,
              NO_ISSUE, NO_ISSUE);
      // one empty entry left, so these offers are dropped
      add_row(make_inst(8'h70, nt, nt), make_inst(8'h71, nt, nt), CDB_IDLE, CDB_IDLE,
              1'b0, NO_ISSUE, NO_ISSUE);
      add_row(make_inst(8'h72, nt, nt), NO_INST, make_cdb(8'h40, WAKE_40), CDB_IDLE,
              1'b0, NO_ISSUE, NO_ISSUE);
      for (o = 8'h00; o < 8'h0E; o = o + 8'h02)
         add_row(NO_INST, NO_INST, CDB_IDLE, CDB_IDLE, o != 8'h00,
                 make_issue(8'h80 | o, operand_a(8'h80 | o), WAKE_40),
                 make_issue(8'h80 | (o + 8'h01), operand_a(8'h80 | (o + 8'h01)), WAKE_40));
      add_row(NO_INST, NO_INST, CDB_IDLE, CDB_IDLE, 1'b1,
              make_issue(8'h8E, operand_a(8'h8E), WAKE_40), NO_ISSUE);
      add_row(NO_INST, NO_INST, CDB_IDLE, CDB_IDLE, 1'b1, NO_ISSUE, NO_ISSUE);
   endtask

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_issue(input string name, input issue_inst_t got,
                              input issue_inst_t exp);
      if (got !== exp)
         abort_run($sformatf("ERR %s got 0x%h expected 0x%h at row %0d",
                             name, got, exp, row_index));
   endtask

   task automatic check_accept(input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("ERR dispatch_accept got 0x%h expected 0x%h at row %0d",
                             got, exp, row_index));
   endtask

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   // limit follows the table length
   initial
   begin
      cycles = 0;
      forever
      begin
         @(posedge clock);
         cycles = cycles + 1;
         if (cycles > RESET_CYCLES + rows.size() + 20)
            abort_run($sformatf("timeout, run did not finish within %0d cycles", cycles));
      end
   end

   initial
   begin
      reset     = 1'b1;
      inst1     = NO_INST;
      inst2     = NO_INST;
      cdb1      = CDB_IDLE;
      cdb2      = CDB_IDLE;
      row_index = 0;
      build_table();
      repeat (RESET_CYCLES) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      for (int r = 0; r < rows.size(); r++)
      begin
         @(negedge clock);
         row_index = r;
         check_accept(dispatch_accept, rows[r].accept);
         check_issue("issue1", issue1, rows[r].issue1);
         check_issue("issue2", issue2, rows[r].issue2);
         inst1 = rows[r].inst1;
         inst2 = rows[r].inst2;
         cdb1  = rows[r].cdb1;
         cdb2  = rows[r].cdb2;
      end
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/reservation_station.sv ====
// Dual-dispatch, dual-issue reservation station
// Peer entries share two CDBs, a dispatch allocator and an age-based issue arbiter

`timescale 1ns/1ns
`default_nettype none

`include "rs_params.svh"

module reservation_station
   import rs_types_pkg::*;
   import rs_ctrl_pkg::*;
(
   input  logic           clock,
   input  logic           reset,
   input  dispatch_inst_t inst1,
   input  dispatch_inst_t inst2,
   input  cdb_t           cdb1,
   input  cdb_t           cdb2,
   output logic           dispatch_accept,
   output issue_inst_t    issue1,
   output issue_inst_t    issue2
);

   entry_status_t  [`RS_NUM_ENTRIES-1:0] statuses;
   issue_inst_t    [`RS_NUM_ENTRIES-1:0] payloads;
   logic           [`RS_NUM_ENTRIES-1:0] fills;
   dispatch_inst_t [`RS_NUM_ENTRIES-1:0] fill_insts;
   age_t           [`RS_NUM_ENTRIES-1:0] fill_ages;
   logic           [1:0]                 fill_count;
   logic           [`RS_NUM_ENTRIES-1:0] issued;

   rs_dispatch_alloc u_alloc (
      .inst1           (inst1),
      .inst2           (inst2),
      .statuses        (statuses),
      .dispatch_accept (dispatch_accept),
      .fill            (fills),
      .fill_insts      (fill_insts),
      .fill_ages       (fill_ages),
      .fill_count      (fill_count)
   );

   for (genvar i = 0; i < `RS_NUM_ENTRIES; i++)
   begin : g_entry
      rs_entry u_entry (
         .clock      (clock),
         .reset      (reset),
         .fill       (fills[i]),
         .fill_inst  (fill_insts[i]),
         .fill_age   (fill_ages[i]),
         .fill_count (fill_count),
         .cdb1       (cdb1),
         .cdb2       (cdb2),
         .issued     (issued[i]),
         .status     (statuses[i]),
         .payload    (payloads[i])
      );
   end

   rs_issue_select u_select (
      .statuses (statuses),
      .payloads (payloads),
      .issued   (issued),
      .issue1   (issue1),
      .issue2   (issue2)
   );

endmodule

`default_nettype wire

// ==== verilog/rs_dispatch_alloc.sv ====
// Dispatch allocator
// Finds the two lowest empty entries and steers the two dispatch slots into them

`timescale 1ns/1ns
`default_nettype none

`include "rs_params.svh"

module rs_dispatch_alloc
   import rs_types_pkg::*;
   import rs_ctrl_pkg::*;
(
   input  dispatch_inst_t                       inst1,
   input  dispatch_inst_t                       inst2,
   input  entry_status_t  [`RS_NUM_ENTRIES-1:0] statuses,
   output logic                                 dispatch_accept,
   output logic           [`RS_NUM_ENTRIES-1:0] fill,
   output dispatch_inst_t [`RS_NUM_ENTRIES-1:0] fill_insts,
   output age_t           [`RS_NUM_ENTRIES-1:0] fill_ages,
   output logic           [1:0]                 fill_count
);

   logic [`RS_NUM_ENTRIES-1:0] first_sel;
   logic [`RS_NUM_ENTRIES-1:0] second_sel;
   logic                       first_found;
   logic                       second_found;
   logic                       take1;
   logic                       take2;

   // priority scan from entry 0 up
   always_comb
   begin
      first_sel    = '0;
      second_sel   = '0;
      first_found  = 1'b0;
      second_found = 1'b0;
      for (int i = 0; i < `RS_NUM_ENTRIES; i++)
      begin
         if (statuses[i].state == EMPTY)
         begin
            if (!first_found)
            begin
               first_sel[i] = 1'b1;
               first_found  = 1'b1;
            end
            else if (!second_found)
            begin
               second_sel[i] = 1'b1;
               second_found  = 1'b1;
            end
         end
      end
   end

   assign dispatch_accept = first_found && second_found;
   assign take1           = dispatch_accept && inst1.valid;
   assign take2           = dispatch_accept && inst2.valid;
   assign fill_count      = {1'b0, take1} + {1'b0, take2};

   // slot 1 always lands in the first empty entry, slot 2 in the second
   always_comb
   begin
      for (int i = 0; i < `RS_NUM_ENTRIES; i++)
      begin
         fill[i]       = (take1 && first_sel[i]) || (take2 && second_sel[i]);
         fill_insts[i] = first_sel[i] ? inst1 : inst2;
         // slot 1 is older than slot 2 when both go in together
         fill_ages[i]  = (first_sel[i] && take1 && take2) ? age_t'(1) : age_t'(0);
      end
   end

endmodule

`default_nettype wire

// ==== verilog/rs_issue_select.sv ====
// Issue arbiter
// Grants the oldest ready entry to port 1 and the next oldest to port 2

`timescale 1ns/1ns
`default_nettype none

`include "rs_params.svh"

module rs_issue_select
   import rs_types_pkg::*;
   import rs_ctrl_pkg::*;
(
   input  entry_status_t [`RS_NUM_ENTRIES-1:0] statuses,
   input  issue_inst_t   [`RS_NUM_ENTRIES-1:0] payloads,
   output logic          [`RS_NUM_ENTRIES-1:0] issued,
   output issue_inst_t                         issue1,
   output issue_inst_t                         issue2
);

   logic [`RS_NUM_ENTRIES-1:0] ready;
   logic [`RS_NUM_ENTRIES-1:0] grant1;
   logic [`RS_NUM_ENTRIES-1:0] grant2;
   // beats[j][i] is set when entry j takes priority over entry i
   logic [`RS_NUM_ENTRIES-1:0] beats [`RS_NUM_ENTRIES];

   always_comb
   begin
      for (int i = 0; i < `RS_NUM_ENTRIES; i++)
         ready[i] = (statuses[i].state == READY);
   end

   // larger age wins, lower index breaks a tie once ages saturate
   always_comb
   begin
      for (int j = 0; j < `RS_NUM_ENTRIES; j++)
      begin
         for (int i = 0; i < `RS_NUM_ENTRIES; i++)
         begin
            beats[j][i] = (statuses[j].age > statuses[i].age) ||
                          ((statuses[j].age == statuses[i].age) && (j < i));
         end
      end
   end

   ////////////////////////////////////////
   // grants
   ////////////////////////////////////////

   always_comb
   begin
      for (int i = 0; i < `RS_NUM_ENTRIES; i++)
      begin
         grant1[i] = ready[i];
         for (int j = 0; j < `RS_NUM_ENTRIES; j++)
         begin
            if (j != i && ready[j] && beats[j][i])
               grant1[i] = 1'b0;
         end
      end
   end

   // port 2 repeats the race among the entries port 1 left behind
   always_comb
   begin
      for (int i = 0; i < `RS_NUM_ENTRIES; i++)
      begin
         grant2[i] = ready[i] && !grant1[i];
         for (int j = 0; j < `RS_NUM_ENTRIES; j++)
         begin
            if (j != i && ready[j] && !grant1[j] && beats[j][i])
               grant2[i] = 1'b0;
         end
      end
   end

   assign issued = grant1 | grant2;

   // grants are one-hot, an idle port stays all zeros
   always_comb
   begin
      issue1 = '0;
      issue2 = '0;
      for (int i = 0; i < `RS_NUM_ENTRIES; i++)
      begin
         if (grant1[i])
            issue1 = payloads[i];
         if (grant2[i])
            issue2 = payloads[i];
      end
   end

endmodule

`default_nettype wire
